/* src/eeprom_pkg.sv */
package eeprom_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int unsigned ADDR_W    = 11;
    localparam int unsigned MEM_DEPTH = 2048;

    typedef logic [ADDR_W-1:0] mem_addr_t;   // Block bits, then word address.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Received byte views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [3:0] dev_code;                // Device type identifier.
        logic [2:0] block;                   // Upper address bits.
        logic       rw;                      // High for read.
    } ctrl_byte_t;

    typedef union packed {
        logic [7:0] raw;                     // Address or data byte.
        ctrl_byte_t ctrl;
    } rx_byte_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage to stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic start;
        logic stop;
        logic scl_rise;
        logic scl_fall;
        logic data_bit;                      // Synchronized data level.
    } bus_event_t;

    typedef struct packed {
        logic     valid;                     // One cycle strobe.
        rx_byte_u value;
    } rx_byte_t;

    typedef struct packed {
        logic       ack_en;                  // Acknowledge the current byte.
        logic       load;                    // Next byte to transmit.
        logic [7:0] value;
    } tx_ctrl_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        mem_addr_t  adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

endpackage

/* src/bus_line_sampler.sv */
`timescale 1ns/1ps

module bus_line_sampler
    import eeprom_pkg::*;
(
    input  logic       sda,
    input  logic       rst_n,
    input  logic       scl,
    input  logic       sdat_in,
    output bus_event_t events
);

    logic [1:0] scl_sync;
    logic [1:0] sdat_sync;
    logic       scl_q;
    logic       sdat_q;
    logic       scl_now;
    logic       sdat_now;

    assign scl_now  = scl_sync[1];
    assign sdat_now = sdat_sync[1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Synchronizers and edge history
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_sync  <= 2'b11;              // Bus idles high.
            sdat_sync <= 2'b11;
            scl_q     <= 1'b1;
            sdat_q    <= 1'b1;
        end
        else
        begin
            scl_sync  <= {scl_sync[0], scl};
            sdat_sync <= {sdat_sync[0], sdat_in};
            scl_q     <= scl_now;
            sdat_q    <= sdat_now;
        end
    end

    // Data edges with scl held high are bus conditions, not bits.
    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            events <= '0;
        end
        else
        begin
            events.start    <= scl_now & scl_q & sdat_q & ~sdat_now;
            events.stop     <= scl_now & scl_q & ~sdat_q & sdat_now;
            events.scl_rise <= scl_now & ~scl_q;
            events.scl_fall <= ~scl_now & scl_q;
            events.data_bit <= sdat_now;
        end
    end

endmodule

/* src/byte_framer.sv */
`timescale 1ns/1ps

module byte_framer
    import eeprom_pkg::*;
(
    input  logic       sda,
    input  logic       rst_n,
    input  bus_event_t events,
    input  tx_ctrl_t   tx,
    output rx_byte_t   rx,
    output logic       master_ack,
    output logic       sdat_oe
);

    logic [3:0] bit_cnt;                     // Bits seen in this frame, 0 to 8.
    logic       tx_mode;
    logic       ack_slot;                    // Between 8th and 9th scl fall.
    logic       ack_pend;
    logic       load_pend;
    logic [7:0] load_val;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       rx_valid;

    assign rx.valid     = rx_valid;
    assign rx.value.raw = rx_shift;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit framing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt    <= '0;
            tx_mode    <= 1'b0;
            ack_slot   <= 1'b0;
            ack_pend   <= 1'b0;
            load_pend  <= 1'b0;
            load_val   <= '0;
            rx_shift   <= '0;
            tx_shift   <= '0;
            rx_valid   <= 1'b0;
            master_ack <= 1'b0;
            sdat_oe    <= 1'b0;
        end
        else
        begin
            rx_valid   <= 1'b0;
            master_ack <= 1'b0;
            if (tx.ack_en)
            begin
                ack_pend <= 1'b1;
            end
            if (tx.load)
            begin
                load_pend <= 1'b1;
                load_val  <= tx.value;
            end

            if (events.start || events.stop)
            begin
                bit_cnt   <= '0;                 // Abort the frame.
                tx_mode   <= 1'b0;
                ack_slot  <= 1'b0;
                ack_pend  <= 1'b0;
                load_pend <= 1'b0;
                sdat_oe   <= 1'b0;
            end
            else if (events.scl_rise)
            begin
                if (bit_cnt == 4'd8)
                begin
                    bit_cnt    <= '0;
                    master_ack <= tx_mode & ~events.data_bit;   // Low means ACK.
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (!tx_mode)
                    begin
                        rx_shift <= {rx_shift[6:0], events.data_bit};   // MSB first.
                        rx_valid <= (bit_cnt == 4'd7);
                    end
                end
            end
            else if (events.scl_fall)
            begin
                if (ack_slot)
                begin
                    // First read bit leaves as the acknowledge ends.
                    ack_slot  <= 1'b0;
                    ack_pend  <= 1'b0;
                    tx_mode   <= load_pend;
                    load_pend <= 1'b0;
                    sdat_oe   <= load_pend & ~load_val[7];
                    tx_shift  <= {load_val[6:0], 1'b0};
                end
                else if (bit_cnt == 4'd8)
                begin
                    ack_slot <= 1'b1;
                    sdat_oe  <= ~tx_mode & ack_pend;    // Master owns the slot in tx.
                end
                else if (tx_mode && bit_cnt != 4'd0)
                begin
                    sdat_oe  <= ~tx_shift[7];           // Pull low for a zero.
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

/* src/eeprom_sequencer.sv */
`timescale 1ns/1ps

module eeprom_sequencer
    import eeprom_pkg::*;
#(
    parameter logic [3:0] DEVICE_CODE = 4'b1010
)
(
    input  logic       sda,
    input  logic       rst_n,
    input  bus_event_t events,
    input  rx_byte_t   rx,
    input  logic       master_ack,
    output tx_ctrl_t   tx,
    output wb_req_t    wb_req,
    input  wb_rsp_t    wb_rsp
);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_CTRL   = 3'd1;
    localparam logic [2:0] ST_WADDR  = 3'd2;
    localparam logic [2:0] ST_WDATA  = 3'd3;
    localparam logic [2:0] ST_READ   = 3'd4;
    localparam logic [2:0] ST_IGNORE = 3'd5;

    logic [2:0] state;
    mem_addr_t  addr;                        // Next location to access.
    logic       bus_abort;
    logic       rd_done;

    assign bus_abort = events.start | events.stop;
    assign rd_done   = wb_rsp.ack & ~wb_req.we & (state == ST_READ) & ~bus_abort;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol FSM and Wishbone master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= ST_IDLE;
            addr   <= '0;
            tx     <= '0;
            wb_req <= '0;
        end
        else
        begin
            tx.ack_en <= 1'b0;
            tx.load   <= 1'b0;

            // A started cycle always runs to its ack.
            if (wb_rsp.ack)
            begin
                wb_req.cyc <= 1'b0;
                wb_req.stb <= 1'b0;
                addr       <= wb_req.adr + 11'd1;    // Wraps at 2048.
            end
            if (rd_done)
            begin
                tx.load  <= 1'b1;
                tx.value <= wb_rsp.dat;
            end

            if (events.start)
            begin
                state <= ST_CTRL;
            end
            else if (events.stop)
            begin
                state <= ST_IDLE;
            end
            else
            begin
                case (state)
                    ST_CTRL:
                    begin
                        if (rx.valid)
                        begin
                            if (rx.value.ctrl.dev_code == DEVICE_CODE)
                            begin
                                tx.ack_en  <= 1'b1;
                                addr[10:8] <= rx.value.ctrl.block;
                                if (rx.value.ctrl.rw)
                                begin
                                    state      <= ST_READ;
                                    wb_req.cyc <= 1'b1;
                                    wb_req.stb <= 1'b1;
                                    wb_req.we  <= 1'b0;
                                    wb_req.adr <= {rx.value.ctrl.block, addr[7:0]};
                                end
                                else
                                begin
                                    state <= ST_WADDR;
                                end
                            end
                            else
                            begin
                                state <= ST_IGNORE;      // Not our device.
                            end
                        end
                    end
                    ST_WADDR:
                    begin
                        if (rx.valid)
                        begin
                            tx.ack_en <= 1'b1;
                            addr[7:0] <= rx.value.raw;
                            state     <= ST_WDATA;
                        end
                    end
                    ST_WDATA:
                    begin
                        if (rx.valid)
                        begin
                            tx.ack_en  <= 1'b1;
                            wb_req.cyc <= 1'b1;
                            wb_req.stb <= 1'b1;
                            wb_req.we  <= 1'b1;
                            wb_req.adr <= addr;
                            wb_req.dat <= rx.value.raw;
                        end
                    end
                    ST_READ:
                    begin
                        if (master_ack)
                        begin
                            wb_req.cyc <= 1'b1;          // Prefetch next byte.
                            wb_req.stb <= 1'b1;
                            wb_req.we  <= 1'b0;
                            wb_req.adr <= addr;
                        end
                    end
                    default:
                    begin
                        state <= state;                  // Idle or ignore.
                    end
                endcase
            end
        end
    end

endmodule

/* src/eeprom_array.sv */
`timescale 1ns/1ps

module eeprom_array
    import eeprom_pkg::*;
(
    input  logic    sda,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic [7:0] mem [MEM_DEPTH];
    logic [7:0] rd_dat;
    logic       ack_q;
    logic       access;

    assign access = wb_req.cyc & wb_req.stb & ~ack_q;   // One ack per request.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sda)
    begin
        if (access)
        begin
            if (wb_req.we)
            begin
                mem[wb_req.adr] <= wb_req.dat;
            end
            rd_dat <= mem[wb_req.adr];
        end
    end

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= access;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat;

endmodule

/* src/i2c_eeprom_top.sv */
`timescale 1ns/1ps

module i2c_eeprom_top
    import eeprom_pkg::*;
#(
    parameter logic [3:0] DEVICE_CODE = 4'b1010
)
(
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic sdat_in,
    output logic sdat_oe
);

    bus_event_t events;
    rx_byte_t   rx;
    tx_ctrl_t   tx;
    logic       master_ack;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;

    bus_line_sampler i_bus_line_sampler (
        .sda     (sda),
        .rst_n   (rst_n),
        .scl     (scl),
        .sdat_in (sdat_in),
        .events  (events)
    );

    byte_framer i_byte_framer (
        .sda        (sda),
        .rst_n      (rst_n),
        .events     (events),
        .tx         (tx),
        .rx         (rx),
        .master_ack (master_ack),
        .sdat_oe    (sdat_oe)
    );

    eeprom_sequencer #(
        .DEVICE_CODE (DEVICE_CODE)
    ) i_eeprom_sequencer (
        .sda        (sda),
        .rst_n      (rst_n),
        .events     (events),
        .rx         (rx),
        .master_ack (master_ack),
        .tx         (tx),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

    eeprom_array i_eeprom_array (
        .sda    (sda),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

endmodule

/* verification/tb_i2c_eeprom.sv */
`timescale 1ns/1ps

module tb_i2c_eeprom
    import eeprom_pkg::*;
();

    localparam logic [3:0] DEV_CODE = 4'b1010;
    localparam int         QTR      = 8;     // System cycles per quarter bit.

    logic        sda;
    logic        rst_n;
    logic        scl;
    logic        master_sdat;
    logic        sdat_line;
    logic        sdat_oe;
    logic [7:0]  ref_mem [MEM_DEPTH];        // Expected array contents.
    logic [7:0]  op_q [$];
    logic [3:0]  dev_q [$];
    mem_addr_t   addr_q [$];
    int          cnt_q [$];
    logic [7:0]  data_q [$];
    logic [7:0]  burst_q [$];
    logic [7:0]  rd_q [$];
    logic [31:0] lcg_state;
    int          bus_bytes;
    int          limit_cycles;

    assign sdat_line = master_sdat & ~sdat_oe;   // Open-drain wired-and.

    i2c_eeprom_top #(
        .DEVICE_CODE (DEV_CODE)
    ) i_i2c_eeprom_top (
        .sda     (sda),
        .rst_n   (rst_n),
        .scl     (scl),
        .sdat_in (sdat_line),
        .sdat_oe (sdat_oe)
    );

    always #4 sda = ~sda;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Run aborted.");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sda);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic clock_bit(input logic b, output logic line, output logic oe);
        wait_cycles(QTR);
        master_sdat = b;
        wait_cycles(QTR);
        scl = 1'b1;
        wait_cycles(QTR);
        line = sdat_line;                    // Middle of the high phase.
        oe   = sdat_oe;
        wait_cycles(QTR);
        scl = 1'b0;
    endtask

    task automatic bus_start();
        wait_cycles(QTR);
        master_sdat = 1'b1;
        wait_cycles(QTR);
        scl = 1'b1;
        wait_cycles(QTR);
        master_sdat = 1'b0;
        wait_cycles(QTR);
        scl = 1'b0;
    endtask

    task automatic bus_stop();
        wait_cycles(QTR);
        master_sdat = 1'b0;
        wait_cycles(QTR);
        scl = 1'b1;
        wait_cycles(QTR);
        master_sdat = 1'b1;
        wait_cycles(QTR);
    endtask

    task automatic write_byte(input logic [7:0] v, input logic acked);
        logic line;
        logic oe;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(v[i], line, oe);
            check_value("sdat_oe", oe, 1'b0);    // Slave quiet while master sends.
        end
        clock_bit(1'b1, line, oe);
        check_value("sdat_oe", oe, acked);
    endtask

    task automatic read_byte(input logic give_ack, output logic [7:0] v);
        logic line;
        logic oe;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, line, oe);
            v[i] = line;
        end
        clock_bit(~give_ack, line, oe);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transactions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic set_pointer(input logic [3:0] dev, input mem_addr_t a, input logic acked);
        bus_start();
        write_byte({dev, a[10:8], 1'b0}, acked);
        write_byte(a[7:0], acked);
    endtask

    task automatic write_burst(input mem_addr_t a);
        mem_addr_t p;
        p = a;
        set_pointer(DEV_CODE, a, 1'b1);
        foreach (burst_q[i])
        begin
            write_byte(burst_q[i], 1'b1);
            ref_mem[p] = burst_q[i];
            p = p + 1'b1;                    // Crosses blocks, wraps at 2048.
        end
        bus_stop();
    endtask

    // Random read with master ACK on all but the last byte.
    task automatic read_burst(input mem_addr_t a, input int n);
        logic [7:0] v;
        rd_q.delete();
        set_pointer(DEV_CODE, a, 1'b1);
        bus_start();
        write_byte({DEV_CODE, a[10:8], 1'b1}, 1'b1);
        for (int i = 0; i < n; i++)
        begin
            read_byte(i < n - 1, v);
            rd_q.push_back(v);
        end
        wait_cycles(QTR);
        check_value("sdat_oe", sdat_oe, 1'b0);   // Line released after NACK.
        bus_stop();
    endtask

    task automatic compare_ref(input mem_addr_t a);
        mem_addr_t p;
        p = a;
        foreach (rd_q[i])
        begin
            check_value("read byte", rd_q[i], ref_mem[p]);
            p = p + 1'b1;
        end
    endtask

    task automatic run_case(input logic [7:0] op, input logic [3:0] dev,
                            input mem_addr_t a, input int n);
        logic [7:0] v;
        logic       line;
        logic       oe;
        burst_q.delete();
        case (op)
            "W":
            begin
                repeat (n) burst_q.push_back(data_q.pop_front());
                write_burst(a);
            end
            "R":
            begin
                read_burst(a, n);
                foreach (rd_q[i])
                    check_value("read byte", rd_q[i], data_q.pop_front());
            end
            "B":
            begin
                set_pointer(dev, a, 1'b0);       // Foreign code is never acknowledged.
                write_byte(data_q.pop_front(), 1'b0);
                bus_stop();
                read_burst(a, 1);
                compare_ref(a);
            end
            "A":
            begin
                set_pointer(DEV_CODE, a, 1'b1);
                v = data_q.pop_front();
                for (int i = 7; i >= 4; i--)
                    clock_bit(v[i], line, oe);
                bus_stop();                      // STOP inside the data byte.
                read_burst(a, 1);
                compare_ref(a);
            end
            default:
            begin
                repeat (n)
                begin
                    lcg_state = lcg_next(lcg_state);
                    burst_q.push_back(lcg_state[23:16]);
                end
                write_burst(a);
                read_burst(a, n);
                compare_ref(a);
            end
        endcase
    endtask

    task automatic load_cases();
        int fd;
        int c;
        int got;
        int dev;
        int blk;
        int adr;
        int cnt;
        int dat;
        fd = $fopen("verification/eeprom_cases.txt", "r");
        if (fd == 0)
            fail_run("Could not open verification/eeprom_cases.txt.");
        c = $fgetc(fd);
        while (c != -1)
        begin
            if (c == "#")
            begin
                while (c != "\n" && c != -1)
                    c = $fgetc(fd);
            end
            else if (c == "W" || c == "R" || c == "B" || c == "A" || c == "S")
            begin
                got = $fscanf(fd, "%h %h %h %d", dev, blk, adr, cnt);
                if (got != 4 || cnt < 1)
                    fail_run("A case line is missing a field or has a zero count.");
                op_q.push_back(c[7:0]);
                dev_q.push_back(dev[3:0]);
                addr_q.push_back({blk[2:0], adr[7:0]});
                cnt_q.push_back(cnt);
                for (int i = 0; i < cnt && c != "S"; i++)
                begin
                    got = $fscanf(fd, "%h", dat);
                    if (got != 1)
                        fail_run("A case line has fewer data bytes than its count.");
                    data_q.push_back(dat[7:0]);
                end
                bus_bytes += 12 + 2 * cnt;       // Generous count of bus bytes.
            end
            else if (c != " " && c != "\n" && c != "\r" && c != "\t")
                fail_run("The case file holds an unknown operation letter.");
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge sda);
        fail_run("Watchdog timeout, the transactions did not finish in time.");
    end

    initial
    begin
        sda         = 1'b0;
        rst_n       = 1'b0;
        scl         = 1'b1;
        master_sdat = 1'b1;
        lcg_state   = 32'h2d7c;
        bus_bytes   = 0;
        load_cases();
        limit_cycles = bus_bytes * 9 * 32 * 2 + 2000;
        wait_cycles(8);
        rst_n = 1'b1;
        repeat (QTR)
        begin
            @(negedge sda);
            check_value("sdat_oe", sdat_oe, 1'b0);
        end
        foreach (op_q[i])
            run_case(op_q[i], dev_q[i], addr_q[i], cnt_q[i]);
        $display("Regression passed");
        $finish;
    end

endmodule

/* verification/eeprom_cases.txt */
# op dev block addr count data... (dev, block, addr, data in hex; count in decimal)
# R lists expected bytes, B uses a foreign dev code, A stops mid byte, S uses LCG data
W a 0 10 1 5a
R a 0 10 1 5a
W a 3 40 4 11 22 33 44
R a 3 40 4 11 22 33 44
W a 7 ff 2 c3 3c
R a 7 ff 2 c3 3c
B 6 0 10 1 a5
B 5 3 41 1 00
A a 3 42 1 f0
A a 0 10 1 0f
S a 1 fc 8
S a 5 fe 3
R a 0 10 1 5a
W a 2 80 1 00
R a 2 80 1 00
W a 2 80 1 ff
B 0 2 80 1 12
R a 2 80 1 ff
R a 3 41 2 22 33

/* build.f */
src/eeprom_pkg.sv
src/bus_line_sampler.sv
src/byte_framer.sv
src/eeprom_sequencer.sv
src/eeprom_array.sv
src/i2c_eeprom_top.sv
verification/tb_i2c_eeprom.sv

/* run_sim.sh */
#!/bin/sh
# Compile the design and testbench with Verilator, then run the model.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_i2c_eeprom \
    --Mdir obj_dir \
    -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_i2c_eeprom)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
